/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // Field widths of the translation path
    localparam int page_base_width = 3;
    localparam int page_index_width = 8;
    localparam int offset_width = 11;

    localparam int logical_width = 16;
    localparam int physical_width = 19;
    localparam int frame_width = 8;
    localparam int data_width = 8;

    typedef logic [logical_width-1:0] logical_addr_t;
    typedef logic [physical_width-1:0] physical_addr_t;
    typedef logic [frame_width-1:0] frame_t; // Physical bits 18:11
    typedef logic [data_width-1:0] data_t;

    // 2'b11 is not assigned and is handled as a read
    typedef enum logic [1:0] {
        op_read = 2'b00,
        op_write = 2'b01,
        op_load_page = 2'b10
    } opcode_t;

    // Page-table load payload
    typedef struct packed {
        logic [page_index_width-1:0] index;
        frame_t frame;
    } page_load_t;

    // Same 16 bits, read as an address or as a table load
    typedef union packed {
        logical_addr_t address;
        page_load_t load;
    } request_payload_u;

    typedef struct packed {
        opcode_t opcode;
        request_payload_u payload;
        data_t write_data; // Only meaningful for op_write
    } request_t;

    // One translated bus operation
    typedef struct packed {
        logic write;
        physical_addr_t address;
        data_t data;
        logic bad_page;
    } bus_op_t;

    typedef struct packed {
        data_t read_data;
        logic write;
        logic bad_page;
    } response_t;

endpackage

`default_nettype wire

/* translate/page_translator.sv */
`default_nettype none

module page_translator (
    input logic clock,
    input logic reset,
    input logic [mmu_pkg::page_base_width-1:0] page_base,
    input mmu_pkg::request_t request,
    input logic request_valid,
    output logic request_ready,
    output mmu_pkg::bus_op_t translated,
    output logic translated_valid,
    input logic translated_ready
);

    localparam int table_entries = 1 << mmu_pkg::page_index_width;
    localparam int page_bits = mmu_pkg::page_index_width - mmu_pkg::page_base_width;

    mmu_pkg::frame_t page_table [table_entries];

    logic request_fire;
    logic is_load;
    logic [mmu_pkg::page_index_width-1:0] table_index;
    mmu_pkg::frame_t table_entry;
    mmu_pkg::physical_addr_t physical;
    logic bad_page;
    mmu_pkg::logical_addr_t logical;

    // Stall while the output register holds an op nobody took
    assign request_ready = !(translated_valid && !translated_ready);
    assign request_fire = request_valid && request_ready;
    assign is_load = (request.opcode == mmu_pkg::op_load_page);

    assign logical = request.payload.address;

    // Base selects a group of 32 pages, upper logical bits pick the page
    assign table_index = {page_base, logical[mmu_pkg::logical_width-1 -: page_bits]};
    assign table_entry = page_table[table_index];
    assign physical = {table_entry, logical[mmu_pkg::offset_width-1:0]};

    // Top six frame bits all ones with bit 11 set
    assign bad_page = (&physical[18:13]) && physical[11];

    // Table writes and valid flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < table_entries; i++) begin
                page_table[i] <= '0;
            end
            translated_valid <= 1'b0;
        end else begin
            if (translated_ready) begin
                translated_valid <= 1'b0;
            end
            if (request_fire) begin
                if (is_load) begin
                    page_table[request.payload.load.index] <= request.payload.load.frame;
                end else begin
                    translated_valid <= 1'b1; // Read or write goes downstream
                end
            end
        end
    end

    // Operation payload loads only on a read or write transfer
    always_ff @(posedge clock) begin
        if (request_fire && !is_load) begin
            translated.write <= (request.opcode == mmu_pkg::op_write);
            translated.address <= physical;
            translated.data <= request.write_data;
            translated.bad_page <= bad_page;
        end
    end

endmodule

`default_nettype wire

/* source/op_queue.sv */
`default_nettype none

module op_queue #(
    parameter int queue_depth = 4
) (
    input logic clock,
    input logic reset,
    input mmu_pkg::bus_op_t translated,
    input logic translated_valid,
    output logic translated_ready,
    output mmu_pkg::bus_op_t head,
    output logic head_valid,
    input logic head_ready
);

    localparam int pointer_width = $clog2(queue_depth);
    localparam int count_width = $clog2(queue_depth + 1);

    mmu_pkg::bus_op_t entries [queue_depth];

    logic [pointer_width-1:0] write_ptr;
    logic [pointer_width-1:0] read_ptr;
    logic [count_width-1:0] count;
    logic push;
    logic pop;

    assign translated_ready = (count != count_width'(queue_depth));
    assign head_valid = (count != '0);
    assign head = entries[read_ptr];

    assign push = translated_valid && translated_ready;
    assign pop = head_valid && head_ready;

    // Depth is a power of two so pointers wrap on their own
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[write_ptr] <= translated;
        end
    end

endmodule

`default_nettype wire

/* bus/bus_cycle_unit.sv */
`default_nettype none

module bus_cycle_unit (
    input logic clock,
    input logic reset,
    input mmu_pkg::bus_op_t head,
    input logic head_valid,
    output logic head_ready,
    output mmu_pkg::physical_addr_t address_bus,
    output mmu_pkg::data_t data_out,
    input mmu_pkg::data_t data_in,
    output logic write_en,
    output mmu_pkg::response_t response,
    output logic response_valid,
    input logic response_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_address, // Address on the bus, reads sample at the end
        st_strobe,  // Write strobe high
        st_respond
    } state_t;

    state_t state;
    mmu_pkg::bus_op_t op; // Operation in progress
    logic take;
    logic write_delayed;
    logic register_space;
    mmu_pkg::data_t read_byte;

    assign head_ready = (state == st_idle);
    assign take = head_valid && head_ready;

    // Low 256 bytes of physical space read back the bus write latch
    assign register_space = (address_bus[18:8] == '0);
    assign read_byte = register_space ? data_out : data_in;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            address_bus <= '0;
            data_out <= '0;
            write_delayed <= 1'b0;
            write_en <= 1'b0;
            response_valid <= 1'b0;
        end else begin
            write_en <= write_delayed; // Strobe lags the load by one cycle
            write_delayed <= 1'b0;
            case (state)
                st_idle: begin
                    if (take) begin
                        address_bus <= head.address;
                        if (head.write) begin
                            data_out <= head.data;
                            write_delayed <= 1'b1;
                        end
                        state <= st_address;
                    end
                end
                st_address: begin
                    if (op.write) begin
                        state <= st_strobe;
                    end else begin
                        response_valid <= 1'b1;
                        state <= st_respond;
                    end
                end
                st_strobe: begin
                    response_valid <= 1'b1;
                    state <= st_respond;
                end
                st_respond: begin
                    if (response_ready) begin
                        response_valid <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Operation and response payload
    always_ff @(posedge clock) begin
        if (take) begin
            op <= head;
        end
        if (state == st_address) begin
            // Writes echo the byte that went out on the bus
            response.read_data <= op.write ? op.data : read_byte;
            response.write <= op.write;
            response.bad_page <= op.bad_page;
        end
    end

endmodule

`default_nettype wire

/* source/cpu6_mmu.sv */
`default_nettype none

module cpu6_mmu #(
    parameter int queue_depth = 4
) (
    input logic clock,
    input logic reset,
    input logic [mmu_pkg::page_base_width-1:0] page_base,
    input mmu_pkg::request_t request,
    input logic request_valid,
    output logic request_ready,
    output mmu_pkg::response_t response,
    output logic response_valid,
    input logic response_ready,
    output mmu_pkg::physical_addr_t address_bus,
    output mmu_pkg::data_t data_out,
    input mmu_pkg::data_t data_in,
    output logic write_en
);

    mmu_pkg::bus_op_t translated;
    logic translated_valid;
    logic translated_ready;
    mmu_pkg::bus_op_t head;
    logic head_valid;
    logic head_ready;

    page_translator u_translator (
        .clock(clock),
        .reset(reset),
        .page_base(page_base),
        .request(request),
        .request_valid(request_valid),
        .request_ready(request_ready),
        .translated(translated),
        .translated_valid(translated_valid),
        .translated_ready(translated_ready)
    );

    // Buffers translated ops while the bus is busy
    op_queue #(
        .queue_depth(queue_depth)
    ) u_queue (
        .clock(clock),
        .reset(reset),
        .translated(translated),
        .translated_valid(translated_valid),
        .translated_ready(translated_ready),
        .head(head),
        .head_valid(head_valid),
        .head_ready(head_ready)
    );

    bus_cycle_unit u_bus (
        .clock(clock),
        .reset(reset),
        .head(head),
        .head_valid(head_valid),
        .head_ready(head_ready),
        .address_bus(address_bus),
        .data_out(data_out),
        .data_in(data_in),
        .write_en(write_en),
        .response(response),
        .response_valid(response_valid),
        .response_ready(response_ready)
    );

endmodule

`default_nettype wire

/* tests/cpu6_mmu_checker.sv */
`default_nettype none

module cpu6_mmu_checker #(
    parameter int name_bits = 160
) (
    input logic clock,
    input logic reset,
    input mmu_pkg::request_t request,
    input logic request_valid,
    input logic request_ready,
    input mmu_pkg::response_t response,
    input logic response_valid,
    input logic response_ready,
    input mmu_pkg::physical_addr_t address_bus,
    input mmu_pkg::data_t data_out,
    input logic write_en,
    input logic [name_bits-1:0] expect_name,
    input mmu_pkg::response_t expect_response,
    input mmu_pkg::physical_addr_t expect_strobe_address,
    input mmu_pkg::data_t expect_strobe_data,
    output int pass_count,
    output int error_count,
    output int pending_count
);

    logic [name_bits-1:0] response_names [$];
    mmu_pkg::response_t response_expected [$];
    logic [name_bits-1:0] strobe_names [$];
    mmu_pkg::physical_addr_t strobe_addresses [$];
    mmu_pkg::data_t strobe_bytes [$];

    task automatic check_strobe();
        logic [name_bits-1:0] name;
        mmu_pkg::physical_addr_t address;
        mmu_pkg::data_t data;
        if (strobe_names.size() == 0) begin
            $display("ERROR: write strobe at %h with no write outstanding", address_bus);
            error_count++;
        end else begin
            name = strobe_names.pop_front();
            address = strobe_addresses.pop_front();
            data = strobe_bytes.pop_front();
            if (address_bus !== address || data_out !== data) begin
                $display("MISMATCH %0s expected strobe %h <= %h actual %h <= %h",
                    name, address, data, address_bus, data_out);
                error_count++;
            end
        end
    endtask

    task automatic check_response();
        logic [name_bits-1:0] name;
        mmu_pkg::response_t expected;
        if (response_names.size() == 0) begin
            $display("ERROR: a response came back with no request outstanding");
            error_count++;
        end else begin
            name = response_names.pop_front();
            expected = response_expected.pop_front();
            if (response !== expected) begin
                // Fields are read data, write and bad_page
                $display("MISMATCH %0s expected %h %b %b actual %h %b %b", name,
                    expected.read_data, expected.write, expected.bad_page,
                    response.read_data, response.write, response.bad_page);
                error_count++;
            end else begin
                $display("PASS %0s data %h bad_page %b", name, response.read_data,
                    response.bad_page);
                pass_count++;
            end
        end
    endtask

    // A handshake seen mid-cycle transfers on the next rising edge
    always @(negedge clock) begin
        if (reset) begin
            response_names.delete();
            response_expected.delete();
            strobe_names.delete();
            strobe_addresses.delete();
            strobe_bytes.delete();
            pass_count = 0;
            error_count = 0;
        end else begin
            if (write_en) begin
                check_strobe();
            end
            if (response_valid && response_ready) begin
                check_response();
            end
            if (request_valid && request_ready) begin
                if (request.opcode == mmu_pkg::op_load_page) begin
                    $display("LOAD %0s", expect_name); // Loads give no response
                end else begin
                    response_names.push_back(expect_name);
                    response_expected.push_back(expect_response);
                    if (request.opcode == mmu_pkg::op_write) begin
                        strobe_names.push_back(expect_name);
                        strobe_addresses.push_back(expect_strobe_address);
                        strobe_bytes.push_back(expect_strobe_data);
                    end
                end
            end
        end
        pending_count = response_names.size() + strobe_names.size();
    end

endmodule

`default_nettype wire

/* tests/cpu6_mmu_properties.sv */
`default_nettype none

module cpu6_mmu_properties (
    input logic clock,
    input logic reset,
    input mmu_pkg::bus_op_t head,
    input logic head_valid,
    input logic head_ready,
    input mmu_pkg::physical_addr_t address_bus,
    input logic write_en,
    input mmu_pkg::response_t response,
    input logic response_valid,
    input logic response_ready
);

    single_strobe: assert property (
        @(posedge clock) disable iff (reset) write_en |=> !write_en
    ) else $error("write_en stayed high for two cycles");

    // Address first, strobe one cycle later on the same address
    strobe_delay: assert property (
        @(posedge clock) disable iff (reset)
        head_valid && head_ready && head.write |=>
            !write_en ##1 (write_en && $stable(address_bus))
    ) else $error("write_en did not follow the write address by one cycle");

    response_hold: assert property (
        @(posedge clock) disable iff (reset)
        response_valid && !response_ready |=> response_valid && $stable(response)
    ) else $error("response changed before it was accepted");

    quiet_in_reset: assert property (@(posedge clock) reset |-> !response_valid)
        else $error("response_valid high during reset");

endmodule

bind bus_cycle_unit cpu6_mmu_properties u_properties (.*);

`default_nettype wire

/* tests/cpu6_mmu_tb.sv */
`default_nettype none

module cpu6_mmu_tb;

    localparam int name_bits = 8 * 20;
    localparam int max_entries = 32;
    localparam int handshake_limit = 200;
    localparam int drain_limit = 2000;

    typedef struct packed {
        logic [name_bits-1:0] name;
        logic [mmu_pkg::page_base_width-1:0] base;
        mmu_pkg::request_t request;
        mmu_pkg::response_t response;
        mmu_pkg::physical_addr_t strobe_address;
        mmu_pkg::data_t strobe_data;
    } test_entry_t;

    logic clock;
    logic reset;
    logic [mmu_pkg::page_base_width-1:0] page_base;
    mmu_pkg::request_t request;
    logic request_valid;
    logic request_ready;
    mmu_pkg::response_t response;
    logic response_valid;
    logic response_ready;
    mmu_pkg::physical_addr_t address_bus;
    mmu_pkg::data_t data_out;
    mmu_pkg::data_t data_in;
    logic write_en;

    test_entry_t current; // Expected values presented with the request
    test_entry_t stimulus [max_entries];
    int entry_count;
    int access_count;
    int timeout_count;
    int pass_count;
    int error_count;
    int pending_count;
    integer seed = 41119;

    mmu_pkg::data_t memory [256]; // Bus memory model
    mmu_pkg::frame_t ref_table [256];
    mmu_pkg::data_t ref_memory [256];
    mmu_pkg::data_t ref_last_write;

    cpu6_mmu #(.queue_depth(4)) u_dut (.*);

    cpu6_mmu_checker #(.name_bits(name_bits)) u_checker (
        .*,
        .expect_name(current.name),
        .expect_response(current.response),
        .expect_strobe_address(current.strobe_address),
        .expect_strobe_data(current.strobe_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Memory byte mixed with the frame bits of the address
    assign data_in = memory[address_bus[7:0]] ^ address_bus[18:11];

    always @(posedge clock) begin
        if (write_en) begin
            memory[address_bus[7:0]] <= data_out;
        end
        response_ready <= reset || ($random(seed) % 3 != 0); // Drops about a third of cycles
    end

    function automatic mmu_pkg::data_t fill_byte(input int address);
        return 8'(address * 37 + 11);
    endfunction

    // Appends one table entry and works out its expected response
    task automatic add_entry(input logic [name_bits-1:0] name, input logic [2:0] base,
            input mmu_pkg::opcode_t opcode, input logic [15:0] payload,
            input mmu_pkg::data_t write_byte);
        test_entry_t entry;
        mmu_pkg::physical_addr_t physical;
        entry = '0;
        entry.name = name;
        entry.base = base;
        entry.request.opcode = opcode;
        entry.request.payload = payload;
        physical = {ref_table[{base, payload[15:11]}], payload[10:0]};
        if (opcode == mmu_pkg::op_load_page) begin
            ref_table[payload[15:8]] = payload[7:0];
        end else begin
            access_count++;
            entry.response.write = (opcode == mmu_pkg::op_write);
            entry.response.bad_page = (physical[18:13] == 6'b111111) && physical[11];
            if (opcode == mmu_pkg::op_write) begin
                entry.request.write_data = write_byte;
                entry.response.read_data = write_byte;
                entry.strobe_address = physical;
                entry.strobe_data = write_byte;
                ref_memory[physical[7:0]] = write_byte;
                ref_last_write = write_byte;
            end else if (physical[18:8] == '0) begin
                entry.response.read_data = ref_last_write; // Register space
            end else begin
                entry.response.read_data = ref_memory[physical[7:0]] ^ physical[18:11];
            end
        end
        stimulus[entry_count] = entry;
        entry_count++;
    endtask

    task automatic build_table();
        mmu_pkg::opcode_t opcode;
        add_entry("read_reg_reset", 3'd0, mmu_pkg::op_read, 16'h0023, 8'h00);
        add_entry("read_low_page", 3'd0, mmu_pkg::op_read, 16'h0123, 8'h00);
        add_entry("load_index_45", 3'd0, mmu_pkg::op_load_page, 16'h4541, 8'h00);
        add_entry("read_frame_41", 3'd2, mmu_pkg::op_read, 16'h2AA7, 8'h00);
        add_entry("write_frame_41", 3'd2, mmu_pkg::op_write, 16'h28B3, 8'h5C);
        add_entry("read_back_write", 3'd2, mmu_pkg::op_read, 16'h28B3, 8'h00);
        add_entry("read_reg_latch", 3'd2, mmu_pkg::op_read, 16'h0010, 8'h00);
        add_entry("write_reg_space", 3'd2, mmu_pkg::op_write, 16'h0042, 8'hA9);
        add_entry("read_reg_other", 3'd2, mmu_pkg::op_read, 16'h0011, 8'h00);
        add_entry("load_index_61", 3'd0, mmu_pkg::op_load_page, 16'h61FD, 8'h00);
        add_entry("load_index_62", 3'd0, mmu_pkg::op_load_page, 16'h62FC, 8'h00);
        add_entry("load_index_63", 3'd0, mmu_pkg::op_load_page, 16'h6340, 8'h00);
        add_entry("read_frame_fd", 3'd3, mmu_pkg::op_read, 16'h0805, 8'h00);
        add_entry("read_frame_fc", 3'd3, mmu_pkg::op_read, 16'h1005, 8'h00);
        add_entry("read_frame_40", 3'd3, mmu_pkg::op_read, 16'h1805, 8'h00);
        for (int i = 0; i < 8; i++) begin
            if (i % 3 == 0) begin
                opcode = mmu_pkg::op_write;
            end else begin
                opcode = mmu_pkg::op_read;
            end
            add_entry({"mixed_", 8'(48 + i)}, 3'd2, opcode,
                16'h2800 + 16'((i % 4) * 3), 8'(8'h30 + i));
        end
    endtask

    // Called on a rising edge, returns on the edge where the request transfers
    task automatic apply_entry(input int k);
        int waited;
        current <= stimulus[k];
        page_base <= stimulus[k].base;
        request <= stimulus[k].request;
        request_valid <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (!request_ready && waited < handshake_limit) begin
            @(negedge clock);
            waited++;
        end
        if (!request_ready) begin
            $display("Timeout: request %0s was not accepted within %0d cycles",
                stimulus[k].name, handshake_limit);
            timeout_count++;
        end else begin
            @(posedge clock);
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < drain_limit) begin
            @(posedge clock);
            waited++;
        end
        if (pending_count != 0) begin
            $display("Timeout: %0d operations never completed", pending_count);
            timeout_count++;
        end else begin
            repeat (10) @(posedge clock); // Room for a late extra response to show up
        end
    endtask

    initial begin
        reset = 1'b1;
        page_base = '0;
        request = '0;
        request_valid = 1'b0;
        response_ready = 1'b1;
        current = '0;
        entry_count = 0;
        access_count = 0;
        timeout_count = 0;
        ref_last_write = '0;
        for (int i = 0; i < 256; i++) begin
            memory[i] = fill_byte(i);
            ref_memory[i] = fill_byte(i);
            ref_table[i] = '0;
        end
        build_table();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        for (int k = 0; k < entry_count && timeout_count == 0; k++) begin
            apply_entry(k);
        end
        request_valid <= 1'b0;
        if (timeout_count == 0) begin
            wait_for_drain();
        end
        $display("Totals: %0d of %0d tests passed, %0d mismatches, %0d timeouts",
            pass_count, access_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && pass_count == access_count) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu6_mmu.f */
common/mmu_pkg.sv
translate/page_translator.sv
source/op_queue.sv
bus/bus_cycle_unit.sv
source/cpu6_mmu.sv
tests/cpu6_mmu_checker.sv
tests/cpu6_mmu_properties.sv
tests/cpu6_mmu_tb.sv

/* Bender.yml */
package:
  name: cpu6_mmu

sources:
  - common/mmu_pkg.sv
  - translate/page_translator.sv
  - source/op_queue.sv
  - bus/bus_cycle_unit.sv
  - source/cpu6_mmu.sv
  - target: test
    files:
      - tests/cpu6_mmu_checker.sv
      - tests/cpu6_mmu_properties.sv
      - tests/cpu6_mmu_tb.sv
